//--- design/ecc_pkg.sv
// ECC field arithmetic package: default operand sizes and shared state/opcode types

package ecc_pkg;

    // --------------------
    // Default sizes
    // --------------------

    // Operand width in bits
    // Kept small by default so simulation runs fast
    parameter int ECC_REG_SIZE = 64;

    // Multiplier word width, must divide ECC_REG_SIZE
    parameter int ECC_RADIX = 16;

    // --------------------
    // Multiplier FSM
    // --------------------

    // Idle, waiting for a start pulse with ready high
    // Loop, one opa word per cycle
    // Final, conditional subtraction and result write
    typedef enum logic [1:0] {
        MULT_IDLE  = 2'd0,
        MULT_LOOP  = 2'd1,
        MULT_FINAL = 2'd2
    } mult_state_t;

    // --------------------
    // Adder opcode
    // --------------------

    // Selects modular add or modular subtract
    typedef enum logic {
        OP_ADD = 1'b0,
        OP_SUB = 1'b1
    } addsub_op_t;

endpackage

//--- design/ecc_op_if.sv
// Operation bus between the field arithmetic unit and one arithmetic engine
`timescale 1ns/10ps

interface ecc_op_if #(
    parameter int REG_SIZE = ecc_pkg::ECC_REG_SIZE
);

    import ecc_pkg::*;

    // Request side
    // One-cycle pulse that launches an operation
    logic                start;
    // Add or subtract, ignored by the multiplier
    addsub_op_t          op;
    logic [REG_SIZE-1:0] opa;
    logic [REG_SIZE-1:0] opb;
    // Field modulus
    logic [REG_SIZE-1:0] prime;

    // Result side
    // Held until the engine writes the next result
    logic [REG_SIZE-1:0] res;
    // Meaning depends on the engine, see the engine modules
    logic                ready;

    // Unit side, issues requests and collects results
    modport requester (
        output start,
        output op,
        output opa,
        output opb,
        output prime,
        input  res,
        input  ready
    );

    // Engine side
    modport engine (
        input  start,
        input  op,
        input  opa,
        input  opb,
        input  prime,
        output res,
        output ready
    );

endinterface

//--- design/ecc_montgomerymultiplier.sv
// Word-serial CIOS Montgomery multiplier, res = opa * opb * 2^-REG_SIZE mod prime
`timescale 1ns/10ps

module ecc_montgomerymultiplier #(
    parameter int REG_SIZE = ecc_pkg::ECC_REG_SIZE,
    parameter int RADIX    = ecc_pkg::ECC_RADIX
) (
    input  logic             clk,
    input  logic             reset_n,

    // Montgomery constant, -prime^-1 mod 2^RADIX
    input  logic [RADIX-1:0] n_prime_i,

    ecc_op_if.engine         bus_if
);

    import ecc_pkg::*;

    // Number of opa words, one loop cycle each
    localparam int WORDS = REG_SIZE / RADIX;
    // Counter needs at least one bit even for a single word
    localparam int CNT_W = (WORDS > 1) ? $clog2(WORDS) : 1;
    localparam logic [CNT_W-1:0] LAST_WORD = CNT_W'(WORDS - 1);

    // Accumulator width
    // acc < 2p, plus a word times opb, plus a digit times p
    // Two guard bits cover the carries of both additions
    localparam int ACC_W  = REG_SIZE + RADIX + 2;
    localparam int PROD_W = REG_SIZE + RADIX;

    mult_state_t         state_q;
    logic [CNT_W-1:0]    word_cnt_q;
    logic [ACC_W-1:0]    acc_q;
    logic [REG_SIZE-1:0] res_q;
    logic                ready_q;

    // Datapath of one loop step
    logic [RADIX-1:0]    a_word;
    logic [PROD_W-1:0]   ab_prod;
    logic [ACC_W-1:0]    sum_ab;
    logic [RADIX-1:0]    q_digit;
    logic [PROD_W-1:0]   qp_prod;
    logic [ACC_W-1:0]    sum_qp;
    logic [ACC_W-1:0]    acc_next;

    // Final correction
    logic [ACC_W-1:0]    prime_ext;
    logic [ACC_W-1:0]    acc_minus_p;
    logic                acc_ge_p;
    logic [REG_SIZE-1:0] res_final;

    // --------------------
    // Loop step
    // --------------------

    // Current word of opa, taken from the live operand
    assign a_word = bus_if.opa[word_cnt_q*RADIX +: RADIX];

    // t = acc + a_i * B
    assign ab_prod = PROD_W'(a_word) * PROD_W'(bus_if.opb);
    assign sum_ab  = acc_q + ACC_W'(ab_prod);

    // Quotient digit makes the low word of t + q*p zero
    // Product truncated to RADIX bits, i.e. mod 2^RADIX
    assign q_digit = sum_ab[RADIX-1:0] * n_prime_i;

    // t + q * p
    assign qp_prod = PROD_W'(q_digit) * PROD_W'(bus_if.prime);
    assign sum_qp  = sum_ab + ACC_W'(qp_prod);

    // Low word is zero here, shift it out
    assign acc_next = sum_qp >> RADIX;

    // --------------------
    // Final correction
    // --------------------

    // Accumulator is below 2p after the loop
    // One subtraction brings it into [0, p)
    assign prime_ext   = ACC_W'(bus_if.prime);
    assign acc_ge_p    = (acc_q >= prime_ext);
    assign acc_minus_p = acc_q - prime_ext;
    assign res_final   = acc_ge_p ? acc_minus_p[REG_SIZE-1:0] : acc_q[REG_SIZE-1:0];

    // --------------------
    // Control FSM
    // --------------------

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state_q    <= MULT_IDLE;
            word_cnt_q <= '0;
            ready_q    <= 1'b1;
            res_q      <= '0;
        end else begin
            case (state_q)
                MULT_IDLE: begin
                    // Start only counts when idle
                    if (bus_if.start) begin
                        state_q    <= MULT_LOOP;
                        word_cnt_q <= '0;
                        ready_q    <= 1'b0;
                    end
                end
                MULT_LOOP: begin
                    word_cnt_q <= word_cnt_q + CNT_W'(1);
                    if (word_cnt_q == LAST_WORD) begin
                        state_q <= MULT_FINAL;
                    end
                end
                MULT_FINAL: begin
                    res_q   <= res_final;
                    ready_q <= 1'b1;
                    state_q <= MULT_IDLE;
                end
                default: begin
                    state_q <= MULT_IDLE;
                    ready_q <= 1'b1;
                end
            endcase
        end
    end

    // --------------------
    // Accumulator
    // --------------------

    // Cleared on an accepted start, updated once per loop cycle
    always_ff @(posedge clk) begin
        if (state_q == MULT_IDLE && bus_if.start) begin
            acc_q <= '0;
        end else if (state_q == MULT_LOOP) begin
            acc_q <= acc_next;
        end
    end

    // Result side of the bus
    assign bus_if.res   = res_q;
    assign bus_if.ready = ready_q;

endmodule

//--- design/ecc_add_sub_mod_alter.sv
// Single-cycle modular adder/subtractor choosing between raw and corrected results
`timescale 1ns/10ps

module ecc_add_sub_mod_alter #(
    parameter int REG_SIZE = ecc_pkg::ECC_REG_SIZE
) (
    input  logic     clk,
    input  logic     reset_n,

    ecc_op_if.engine bus_if
);

    import ecc_pkg::*;

    // One extra bit catches the carry of add and the borrow of subtract
    localparam int EXT_W = REG_SIZE + 1;

    logic [EXT_W-1:0]    opa_ext;
    logic [EXT_W-1:0]    opb_ext;
    logic [EXT_W-1:0]    prime_ext;

    // Add candidates
    logic [EXT_W-1:0]    sum_raw;
    logic [EXT_W-1:0]    sum_fix;
    logic                sum_ge_p;
    logic [REG_SIZE-1:0] add_res;

    // Subtract candidates
    logic [EXT_W-1:0]    diff_raw;
    logic [REG_SIZE-1:0] diff_fix;
    logic                borrow;
    logic [REG_SIZE-1:0] sub_res;

    logic [REG_SIZE-1:0] res_next;
    logic [REG_SIZE-1:0] res_q;
    logic                ready_q;

    assign opa_ext   = {1'b0, bus_if.opa};
    assign opb_ext   = {1'b0, bus_if.opb};
    assign prime_ext = {1'b0, bus_if.prime};

    // --------------------
    // Add path
    // --------------------

    // Operands are below p, so sum < 2p
    // At most one subtraction of p is needed
    assign sum_raw  = opa_ext + opb_ext;
    assign sum_fix  = sum_raw - prime_ext;
    assign sum_ge_p = (sum_raw >= prime_ext);
    assign add_res  = sum_ge_p ? sum_fix[REG_SIZE-1:0] : sum_raw[REG_SIZE-1:0];

    // --------------------
    // Subtract path
    // --------------------

    // Top bit of the extended difference is the borrow
    assign diff_raw = opa_ext - opb_ext;
    assign borrow   = diff_raw[REG_SIZE];
    // Adding p wraps the negative difference back into range
    assign diff_fix = diff_raw[REG_SIZE-1:0] + bus_if.prime;
    assign sub_res  = borrow ? diff_fix : diff_raw[REG_SIZE-1:0];

    // Opcode select
    assign res_next = (bus_if.op == OP_SUB) ? sub_res : add_res;

    // --------------------
    // Result register
    // --------------------

    // Result loads on start and holds otherwise
    // Ready pulses in the cycle after start
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            res_q   <= '0;
            ready_q <= 1'b0;
        end else begin
            ready_q <= bus_if.start;
            if (bus_if.start) begin
                res_q <= res_next;
            end
        end
    end

    assign bus_if.res   = res_q;
    assign bus_if.ready = ready_q;

endmodule

//--- design/ecc_fau.sv
// ECC finite field arithmetic unit with Montgomery multiplier and modular adder
`timescale 1ns/10ps

module ecc_fau #(
    parameter int REG_SIZE = ecc_pkg::ECC_REG_SIZE,
    parameter int RADIX    = ecc_pkg::ECC_RADIX
) (
    input  logic                clk,
    input  logic                reset_n,

    // Controls
    // Add enable is a strobe, multiply enable is a level
    input  logic                add_en_i,
    input  logic                sub_i,
    input  logic                mult_en_i,

    // Operands, must stay stable during a multiply
    input  logic [REG_SIZE-1:0] prime_i,
    input  logic [RADIX-1:0]    mult_mu_i,
    input  logic [REG_SIZE-1:0] opa_i,
    input  logic [REG_SIZE-1:0] opb_i,

    // Results, held until the next operation
    output logic [REG_SIZE-1:0] add_res_o,
    output logic [REG_SIZE-1:0] mult_res_o
);

    import ecc_pkg::*;

    // Registered controls
    logic add_en_q;
    logic sub_q;
    logic mult_en_q;
    logic mult_en_dly_q;

    // One-cycle pulse on the rising edge of the registered enable
    logic mult_start;

    // Request buses, one per engine
    ecc_op_if #(.REG_SIZE(REG_SIZE)) mult_bus ();
    ecc_op_if #(.REG_SIZE(REG_SIZE)) add_bus ();

    // --------------------
    // Control registers
    // --------------------

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            add_en_q      <= 1'b0;
            sub_q         <= 1'b0;
            mult_en_q     <= 1'b0;
            mult_en_dly_q <= 1'b0;
        end else begin
            add_en_q      <= add_en_i;
            sub_q         <= sub_i;
            mult_en_q     <= mult_en_i;
            mult_en_dly_q <= mult_en_q;
        end
    end

    // Holding the level high gives a single start
    assign mult_start = mult_en_q & ~mult_en_dly_q;

    // --------------------
    // Multiplier bus
    // --------------------

    assign mult_bus.start = mult_start;
    // Opcode has no meaning for the multiplier
    assign mult_bus.op    = OP_ADD;
    assign mult_bus.opa   = opa_i;
    assign mult_bus.opb   = opb_i;
    assign mult_bus.prime = prime_i;

    ecc_montgomerymultiplier #(
        .REG_SIZE(REG_SIZE),
        .RADIX   (RADIX)
    ) u_mult (
        .clk      (clk),
        .reset_n  (reset_n),
        .n_prime_i(mult_mu_i),
        .bus_if   (mult_bus.engine)
    );

    // --------------------
    // Adder bus
    // --------------------

    // Registered add enable is already a one-cycle strobe
    assign add_bus.start = add_en_q;
    assign add_bus.op    = sub_q ? OP_SUB : OP_ADD;
    assign add_bus.opa   = opa_i;
    assign add_bus.opb   = opb_i;
    assign add_bus.prime = prime_i;

    ecc_add_sub_mod_alter #(
        .REG_SIZE(REG_SIZE)
    ) u_addsub (
        .clk    (clk),
        .reset_n(reset_n),
        .bus_if (add_bus.engine)
    );

    // Results straight from the engine registers
    assign mult_res_o = mult_bus.res;
    assign add_res_o  = add_bus.res;

endmodule

//--- bench/ecc_fau_props.sv
// Concurrent checks on reset state, result hold and multiplier start/ready sequencing
`timescale 1ns/10ps

module ecc_fau_props #(
    parameter int REG_SIZE = ecc_pkg::ECC_REG_SIZE,
    parameter int RADIX    = ecc_pkg::ECC_RADIX
) (
    input logic                  clk,
    input logic                  reset_n,
    input logic                  add_start,
    input logic [REG_SIZE-1:0]   add_res,
    input logic                  mult_en_q,
    input logic                  mult_start,
    input logic                  mult_ready,
    input logic [REG_SIZE-1:0]   mult_res,
    input ecc_pkg::mult_state_t  mult_state
);

    import ecc_pkg::*;

    localparam int WORDS = REG_SIZE / RADIX;

    // --------------------
    // Reset and hold
    // --------------------

    reset_state_a: assert property (@(posedge clk)
        $rose(reset_n) |-> (add_res == '0) && (mult_res == '0) && mult_ready)
        else $error("Results or multiplier ready not at reset values");

    // Adder result only loads on a registered enable
    add_hold_a: assert property (@(posedge clk) disable iff (!reset_n)
        !add_start |=> $stable(add_res))
        else $error("Add result changed without an add enable");

    mult_hold_a: assert property (@(posedge clk) disable iff (!reset_n)
        mult_ready && !mult_start |=> $stable(mult_res))
        else $error("Multiply result changed while idle");

    // --------------------
    // Multiplier start and ready
    // --------------------

    // Enable held high past its rising edge, a finished multiplier stays idle
    single_start_a: assert property (@(posedge clk) disable iff (!reset_n)
        mult_ready && mult_en_q && $past(mult_en_q) |=> mult_ready)
        else $error("Multiplier restarted while multiply enable stayed high");

    start_accept_a: assert property (@(posedge clk) disable iff (!reset_n)
        mult_start && mult_ready |=> !mult_ready)
        else $error("Idle multiplier ignored a start");

    ready_fall_a: assert property (@(posedge clk) disable iff (!reset_n)
        $fell(mult_ready) |-> $past(mult_start))
        else $error("Multiplier went busy without a start");

    // W loop cycles plus the final cycle
    ready_rise_a: assert property (@(posedge clk) disable iff (!reset_n)
        $fell(mult_ready) |-> ##(WORDS + 1) $rose(mult_ready))
        else $error("Multiplier ready did not return after the expected cycles");

    ready_state_a: assert property (@(posedge clk) disable iff (!reset_n)
        mult_ready == (mult_state == MULT_IDLE))
        else $error("Multiplier ready does not match the FSM state");

endmodule

bind ecc_fau ecc_fau_props #(
    .REG_SIZE(REG_SIZE),
    .RADIX   (RADIX)
) u_props (
    .clk       (clk),
    .reset_n   (reset_n),
    .add_start (add_bus.start),
    .add_res   (add_res_o),
    .mult_en_q (mult_en_q),
    .mult_start(mult_start),
    .mult_ready(mult_bus.ready),
    .mult_res  (mult_res_o),
    .mult_state(u_mult.state_q)
);

//--- bench/ecc_fau_tb.sv
// Testbench for the ECC field arithmetic unit with add, subtract and Montgomery multiply checks
`timescale 1ns/10ps

module ecc_fau_tb;

    localparam int REG_SIZE = 64;
    localparam int RADIX    = 16;
    localparam int WORDS    = REG_SIZE / RADIX;
    // Clock cycles allowed for any single wait
    localparam int TIMEOUT  = 100;

    logic                clk;
    logic                reset_n;
    logic                add_en_i;
    logic                sub_i;
    logic                mult_en_i;
    logic [REG_SIZE-1:0] prime_i;
    logic [RADIX-1:0]    mult_mu_i;
    logic [REG_SIZE-1:0] opa_i;
    logic [REG_SIZE-1:0] opb_i;
    logic [REG_SIZE-1:0] add_res_o;
    logic [REG_SIZE-1:0] mult_res_o;

    // Reference model values, read by the checks
    logic [REG_SIZE-1:0]   exp_add;
    logic [2*REG_SIZE-1:0] exp_mult;

    logic [31:0]         lfsr_state;
    logic                failed;
    logic                passed;
    logic [REG_SIZE-1:0] primes [2];

    ecc_fau #(
        .REG_SIZE(REG_SIZE),
        .RADIX   (RADIX)
    ) uut (
        .clk       (clk),
        .reset_n   (reset_n),
        .add_en_i  (add_en_i),
        .sub_i     (sub_i),
        .mult_en_i (mult_en_i),
        .prime_i   (prime_i),
        .mult_mu_i (mult_mu_i),
        .opa_i     (opa_i),
        .opb_i     (opb_i),
        .add_res_o (add_res_o),
        .mult_res_o(mult_res_o)
    );

    // 20 ns clock
    always #10 clk = ~clk;

    // --------------------
    // Stimulus helpers
    // --------------------

    // Galois LFSR, x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // One LFSR step per bit, then reduced below the modulus
    task automatic rand_below(input logic [REG_SIZE-1:0] p, output logic [REG_SIZE-1:0] v);
        logic [REG_SIZE-1:0] r;
        for (int i = 0; i < REG_SIZE; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            r[i] = lfsr_state[0];
        end
        v = r % p;
    endtask

    // Newton iteration for p^-1 mod 2^64, odd p is its own inverse mod 8
    // Each step doubles the correct bits, result negated for the multiplier
    function automatic logic [RADIX-1:0] mont_const(input logic [REG_SIZE-1:0] p);
        logic [REG_SIZE-1:0] x;
        x = p;
        for (int k = 0; k < 5; k++) begin
            x = x * (64'd2 - p * x);
        end
        x = ~x + 64'd1;
        return x[RADIX-1:0];
    endfunction

    task automatic check_eq(input logic [REG_SIZE-1:0] got, input logic [REG_SIZE-1:0] expv,
                            input string what);
        assert (got === expv) else begin
            $display("Error: %0t ns: %s got %h expected %h", $time, what, got, expv);
            $display("Test failed");
            failed = 1'b1;
            $fatal(1, "result mismatch");
        end
    endtask

    task automatic timeout_fail(input string what);
        $display("Timeout: %s did not arrive within %0d clock cycles", what, TIMEOUT);
        $display("Test failed");
        failed = 1'b1;
        $fatal(1, "wait timed out");
    endtask

    task automatic wait_edges(input int n);
        for (int i = 0; i < n; i++) begin
            @(posedge clk);
            @(negedge clk);
        end
    endtask

    // --------------------
    // Operations
    // --------------------

    // Called at a falling edge, returns at a falling edge
    task automatic run_addsub(input logic [REG_SIZE-1:0] a, input logic [REG_SIZE-1:0] b,
                              input logic sub);
        logic [REG_SIZE:0] wide;
        int                edges;
        if (sub) begin
            wide = ({1'b0, a} + {1'b0, prime_i} - {1'b0, b}) % {1'b0, prime_i};
        end else begin
            wide = ({1'b0, a} + {1'b0, b}) % {1'b0, prime_i};
        end
        exp_add  = wide[REG_SIZE-1:0];
        opa_i    = a;
        opb_i    = b;
        sub_i    = sub;
        add_en_i = 1'b1;
        edges    = 0;
        // Adder ready pulses once the result register is loaded
        // The pulse of the previous operation may still be high here
        do begin
            @(posedge clk);
            edges++;
            @(negedge clk);
            add_en_i = 1'b0;
            if (!uut.add_bus.ready && edges >= TIMEOUT) timeout_fail("adder ready pulse");
        end while (!uut.add_bus.ready);
        check_eq(REG_SIZE'(edges), REG_SIZE'(2), "adder latency");
        check_eq(add_res_o, exp_add, sub ? "modular subtract" : "modular add");
    endtask

    // Holds the enable for hold extra cycles after the result
    task automatic run_mult(input logic [REG_SIZE-1:0] a, input logic [REG_SIZE-1:0] b,
                            input int hold);
        logic [2*REG_SIZE-1:0] lhs;
        logic                  seen_low;
        int                    edges;
        exp_mult  = ((2*REG_SIZE)'(a) * (2*REG_SIZE)'(b)) % (2*REG_SIZE)'(prime_i);
        opa_i     = a;
        opb_i     = b;
        mult_en_i = 1'b1;
        seen_low  = 1'b0;
        edges     = 0;
        while (!(seen_low && uut.mult_bus.ready)) begin
            @(posedge clk);
            edges++;
            @(negedge clk);
            if (!uut.mult_bus.ready) seen_low = 1'b1;
            if (!(seen_low && uut.mult_bus.ready) && edges >= TIMEOUT) begin
                timeout_fail("multiplier ready");
            end
        end
        // Edges 0 through W+2, the result is written at edge W+2
        check_eq(REG_SIZE'(edges), REG_SIZE'(WORDS + 3), "multiply latency");
        // res * R mod p must match a * b mod p
        lhs = {mult_res_o, {REG_SIZE{1'b0}}} % {{REG_SIZE{1'b0}}, prime_i};
        check_eq(lhs[REG_SIZE-1:0], exp_mult[REG_SIZE-1:0], "Montgomery product");
        assert (mult_res_o < prime_i) else begin
            $display("Error: %0t ns: product %h is not below modulus %h", $time, mult_res_o,
                     prime_i);
            $display("Test failed");
            failed = 1'b1;
            $fatal(1, "product out of range");
        end
        wait_edges(hold);
        mult_en_i = 1'b0;
        wait_edges(2);
    endtask

    // --------------------
    // Main sequence
    // --------------------

    initial begin
        logic [REG_SIZE-1:0] a;
        logic [REG_SIZE-1:0] b;
        primes[0]  = 64'hFFFF_FFFF_FFFF_FFC5;
        primes[1]  = 64'hD2B4_9A1C_7E35_0F6B;
        clk        = 1'b0;
        reset_n    = 1'b0;
        add_en_i   = 1'b0;
        sub_i      = 1'b0;
        mult_en_i  = 1'b0;
        prime_i    = primes[0];
        mult_mu_i  = '0;
        opa_i      = '0;
        opb_i      = '0;
        lfsr_state = 32'd30;
        failed     = 1'b0;
        passed     = 1'b0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        reset_n = 1'b1;
        for (int pi = 0; pi < 2; pi++) begin
            prime_i   = primes[pi];
            mult_mu_i = mont_const(prime_i);
            // Sums across p and the largest operands
            run_addsub(prime_i - 64'd1, prime_i - 64'd1, 1'b0);
            run_addsub(prime_i - 64'd1, 64'd1, 1'b0);
            run_addsub(64'd0, 64'd0, 1'b0);
            // Borrow case and a zero difference
            run_addsub(64'd0, 64'd1, 1'b1);
            run_addsub(64'd5, 64'd5, 1'b1);
            for (int n = 0; n < 16; n++) begin
                rand_below(prime_i, a);
                rand_below(prime_i, b);
                run_addsub(a, b, n[0]);
            end
            run_mult(64'd0, b, 0);
            run_mult(64'd1, 64'd1, 0);
            run_mult(prime_i - 64'd1, prime_i - 64'd1, 0);
            // Long enable, no second start, add result untouched
            run_mult(a, b, 3 * WORDS);
            check_eq(add_res_o, exp_add, "add result held");
            for (int n = 0; n < 6; n++) begin
                rand_below(prime_i, a);
                rand_below(prime_i, b);
                run_mult(a, b, 0);
            end
        end
        if (failed) begin
            $display("Test failed");
        end else begin
            passed = 1'b1;
            $display("Test passed");
        end
        $finish;
    end

    // A stop from a bound assertion ends up here
    final begin
        if (!passed && !failed) $display("Test failed");
    end

endmodule

//--- files.f
design/ecc_pkg.sv
design/ecc_op_if.sv
design/ecc_montgomerymultiplier.sv
design/ecc_add_sub_mod_alter.sv
design/ecc_fau.sv
bench/ecc_fau_props.sv
bench/ecc_fau_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build with Verilator, run, and look for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --timescale 1ns/10ps -f files.f \
    --top-module ecc_fau_tb -o ecc_fau_sim > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/ecc_fau_sim > sim.log 2>&1 || true
cat sim.log
grep -qx "Test passed" sim.log && exit 0 || exit 1
